// ==== common/spram_pkg.sv ====
// Shared widths, vector types and bus structs for the tiled SRAM subsystem.
// Every design and testbench file refers to these by scoped name.
// Data and address widths are fixed here; geometry and credit depths are
// module parameters set at the top level.

package spram_pkg;

  localparam int DATA_W = 32;  // memory word width
  localparam int ADDR_W = 10;  // word address width
  localparam int TAG_W  = 4;   // read tag width

  typedef logic [DATA_W-1:0] data_t;  // one memory word
  typedef logic [DATA_W-1:0] mask_t;  // per bit write mask, 1 = write
  typedef logic [ADDR_W-1:0] addr_t;  // word address
  typedef logic [TAG_W-1:0]  tag_t;   // echoed on the read response

  // request from the requester, 79 bits
  typedef struct packed {
    logic  write;  // 1 = write, 0 = read
    addr_t addr;
    mask_t mask;   // ignored on reads
    data_t data;   // ignored on reads
    tag_t  tag;    // ignored on writes
  } mem_req_t;

  // read response, 36 bits
  typedef struct packed {
    tag_t  tag;
    data_t data;
  } mem_rsp_t;

  // issued command from decode into the tiled array
  typedef struct packed {
    logic  en;     // command valid this cycle
    logic  write;
    addr_t addr;   // array uses low bits as row, upper bits as bank
    mask_t mask;
    data_t data;
    tag_t  tag;    // forwarded to the result stage
  } array_cmd_t;

endpackage

// ==== mem_array/mem_tile.sv ====
// Behavioral model of one single-port SRAM macro.
// Writes touch only bits whose mask is set; reads register the word
// into dout one clock after the command. dout holds otherwise.

module mem_tile #(
  parameter int TILE_W      = 16,
  parameter int TILE_ADDR_W = 8
) (
  input  logic                   clk,
  input  logic                   ce,     // chip enable
  input  logic                   we,     // write enable qualified by ce
  input  logic [TILE_ADDR_W-1:0] addr,   // row
  input  logic [TILE_W-1:0]      wmask,  // per bit write mask
  input  logic [TILE_W-1:0]      din,
  output logic [TILE_W-1:0]      dout
);

  localparam int ROWS = 2 ** TILE_ADDR_W;

  logic [TILE_W-1:0] mem [ROWS];  // one word per row

  always_ff @(posedge clk) begin
    if (ce && we) begin
      mem[addr] <= (mem[addr] & ~wmask) | (din & wmask);  // merge masked bits
    end
  end

  always_ff @(posedge clk) begin
    if (ce && !we) begin
      dout <= mem[addr];  // registered read
    end
  end

endmodule

// ==== mem_array/mem_array.sv ====
// Tiled memory array built from mem_tile macros.
// The word is split into columns of TILE_W bits and the address space into
// banks of 2^TILE_ADDR_W rows. Enables are gated per bank; the outputs of
// the bank read last are kept and all banks are OR-combined into rd_data.

module mem_array #(
  parameter int TILE_W      = 16,
  parameter int TILE_ADDR_W = 8
) (
  input  logic                  clk,
  input  spram_pkg::array_cmd_t cmd,
  output spram_pkg::data_t      rd_data
);

  localparam int DATA_W    = spram_pkg::DATA_W;
  localparam int ADDR_W    = spram_pkg::ADDR_W;
  localparam int BANK_BITS = (ADDR_W > TILE_ADDR_W) ? ADDR_W - TILE_ADDR_W : 0;
  localparam int BANKS     = 2 ** BANK_BITS;
  localparam int BANK_W    = (BANK_BITS > 0) ? BANK_BITS : 1;
  localparam int COLS      = (DATA_W + TILE_W - 1) / TILE_W;  // last one may be partial

  logic [TILE_ADDR_W-1:0]        row;        // row inside every tile
  logic [BANK_W-1:0]             bank_idx;   // bank of current command
  logic [BANK_W-1:0]             rd_bank_q;  // bank of the last read
  logic [BANKS-1:0][DATA_W-1:0]  bank_word;  // per bank output, zero when unselected

  assign row = cmd.addr[TILE_ADDR_W-1:0];

  if (BANK_BITS > 0) begin : g_multi_bank
    assign bank_idx = cmd.addr[ADDR_W-1:TILE_ADDR_W];  // upper bits pick the bank
  end else begin : g_single_bank
    assign bank_idx = '0;  // whole depth fits one tile
  end

  always_ff @(posedge clk) begin
    if (cmd.en && !cmd.write) begin
      rd_bank_q <= bank_idx;  // aligns with tile dout
    end
  end

  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    logic sel;     // command targets this bank
    logic rd_sel;  // this bank owns the read data
    logic ce;
    logic we;

    assign sel    = (bank_idx == BANK_W'(b));
    assign rd_sel = (rd_bank_q == BANK_W'(b));
    assign ce     = cmd.en && sel;
    assign we     = cmd.write && ce;

    for (genvar c = 0; c < COLS; c++) begin : g_col
      logic [TILE_W-1:0] t_din;
      logic [TILE_W-1:0] t_mask;
      logic [TILE_W-1:0] t_dout;

      for (genvar i = 0; i < TILE_W; i++) begin : g_bit
        if (c * TILE_W + i < DATA_W) begin : g_used
          assign t_din[i]  = cmd.data[c*TILE_W+i];
          assign t_mask[i] = cmd.mask[c*TILE_W+i];
          assign bank_word[b][c*TILE_W+i] = rd_sel ? t_dout[i] : 1'b0;
        end else begin : g_pad
          assign t_din[i]  = 1'b0;  // beyond the word, never written
          assign t_mask[i] = 1'b0;
        end
      end

      mem_tile #(
        .TILE_W      (TILE_W),
        .TILE_ADDR_W (TILE_ADDR_W)
      ) u_tile (
        .clk   (clk),
        .ce    (ce),
        .we    (we),
        .addr  (row),
        .wmask (t_mask),
        .din   (t_din),
        .dout  (t_dout)
      );
    end
  end

  // one bank is selected, the rest contribute zero
  always_comb begin
    rd_data = '0;
    for (int b = 0; b < BANKS; b++) begin
      rd_data = rd_data | bank_word[b];
    end
  end

endmodule

// ==== hw/spram_decode.sv ====
// Request queue and issue stage for the SRAM subsystem.
// Commands are queued in order; the head issues as one registered array
// command per cycle. Reads wait for a response credit, writes do not.
// Each pop returns one request credit to the requester a cycle later.

module spram_decode #(
  parameter int REQ_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_valid,
  input  spram_pkg::mem_req_t   req,
  output logic                  req_credit,
  input  logic                  rsp_credit_ok,
  output spram_pkg::array_cmd_t cmd,
  output logic                  issue_rd
);

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  spram_pkg::mem_req_t queue [REQ_DEPTH];  // command storage
  spram_pkg::mem_req_t head;               // oldest entry
  spram_pkg::mem_req_t cmd_req;            // payload of the issued command

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;    // entries held
  logic             issue;    // pop head this cycle
  logic             cmd_en;   // issued command valid

  // wraps at any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(REQ_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign head  = queue[rd_ptr];
  assign issue = (count != '0) && (head.write || rsp_credit_ok);  // writes skip credit check

  // debit lands in the result stage on the same edge as the pop
  assign issue_rd = issue && !head.write;

  always_ff @(posedge clk) begin
    if (req_valid) begin
      queue[wr_ptr] <= req;  // requester only sends with a credit in hand
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
      cmd_en     <= 1'b0;
    end else begin
      if (req_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (issue) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({req_valid, issue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
      req_credit <= issue;  // hand the freed slot back
      cmd_en     <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      cmd_req <= head;  // payload held between commands
    end
  end

  assign cmd = '{
    en:    cmd_en,
    write: cmd_req.write,
    addr:  cmd_req.addr,
    mask:  cmd_req.mask,
    data:  cmd_req.data,
    tag:   cmd_req.tag
  };

endmodule

// ==== hw/spram_result.sv ====
// Result stage of the SRAM subsystem.
// Holds the response credit count used to gate reads in decode, lines up
// the read tag with the array data and registers the response.
// A read issued on cycle N answers with rsp_valid on cycle N+3.

module spram_result #(
  parameter int RSP_CREDITS = 2
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                issue_rd,      // read popped this cycle
  input  spram_pkg::tag_t     cmd_tag,       // tag of the command in the array
  input  spram_pkg::data_t    rd_data,
  input  logic                rsp_credit,    // consumer returns one slot
  output logic                rsp_credit_ok,
  output logic                rsp_valid,
  output spram_pkg::mem_rsp_t rsp
);

  localparam int CNT_W = $clog2(RSP_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;  // response slots held
  logic             rd_cmd_q;    // read command in the array
  logic             rd_data_q;   // read data on rd_data
  spram_pkg::tag_t  tag_q;       // tag aligned with rd_data

  assign rsp_credit_ok = (credit_cnt != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= CNT_W'(RSP_CREDITS);
      rd_cmd_q   <= 1'b0;
      rd_data_q  <= 1'b0;
      rsp_valid  <= 1'b0;
    end else begin
      case ({rsp_credit, issue_rd})
        2'b10: begin
          if (credit_cnt != CNT_W'(RSP_CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;  // saturate at the initial grant
          end
        end
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;  // both cancel out
      endcase
      rd_cmd_q  <= issue_rd;
      rd_data_q <= rd_cmd_q;
      rsp_valid <= rd_data_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_cmd_q) begin
      tag_q <= cmd_tag;  // tag leaves decode with the command
    end
    if (rd_data_q) begin
      rsp <= '{tag: tag_q, data: rd_data};
    end
  end

endmodule

// ==== hw/spram_top.sv ====
// Top level of the tiled SRAM subsystem.
// Requests enter under request credits, responses leave under response
// credits. Sets geometry and credit depths for the submodules.

module spram_top #(
  parameter int REQ_DEPTH   = 4,
  parameter int RSP_CREDITS = 2,
  parameter int TILE_W      = 16,
  parameter int TILE_ADDR_W = 8
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                req_valid,
  input  spram_pkg::mem_req_t req,
  output logic                req_credit,
  output logic                rsp_valid,
  output spram_pkg::mem_rsp_t rsp,
  input  logic                rsp_credit
);

  spram_pkg::array_cmd_t cmd;            // decode to array
  spram_pkg::data_t      rd_data;        // array to result
  logic                  issue_rd;       // read popped, debit a credit
  logic                  rsp_credit_ok;  // result allows a read

  spram_decode #(
    .REQ_DEPTH (REQ_DEPTH)
  ) u_decode (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .req_credit    (req_credit),
    .rsp_credit_ok (rsp_credit_ok),
    .cmd           (cmd),
    .issue_rd      (issue_rd)
  );

  mem_array #(
    .TILE_W      (TILE_W),
    .TILE_ADDR_W (TILE_ADDR_W)
  ) u_array (
    .clk     (clk),
    .cmd     (cmd),
    .rd_data (rd_data)
  );

  spram_result #(
    .RSP_CREDITS (RSP_CREDITS)
  ) u_result (
    .clk           (clk),
    .reset         (reset),
    .issue_rd      (issue_rd),
    .cmd_tag       (cmd.tag),
    .rd_data       (rd_data),
    .rsp_credit    (rsp_credit),
    .rsp_credit_ok (rsp_credit_ok),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
  );

endmodule

// ==== tests/spram_sva.sv ====
// Concurrent checks on the credit rules of spram_top.
// Attached to every spram_top by the bind at the end of this file.

module spram_sva #(
  parameter int RSP_CREDITS = 2
) (
  input logic                             clk,
  input logic                             reset,
  input logic                             req_credit,
  input logic                             rsp_valid,
  input logic                             rsp_credit,
  input logic [$clog2(RSP_CREDITS+1)-1:0] credit_cnt  // result stage counter
);
  timeunit 1ns;
  timeprecision 1ps;

  int held;  // free slots on the consumer side

  always_ff @(posedge clk) begin
    if (reset) begin
      held <= RSP_CREDITS;
    end else begin
      held <= held - int'(rsp_valid) + int'(rsp_credit);
    end
  end

  a_rsp_needs_credit: assert property (
    @(posedge clk) disable iff (reset) rsp_valid |-> held > 0
  ) else $error("response sent while the consumer had no free slot");

  a_credit_max: assert property (
    @(posedge clk) disable iff (reset) int'(credit_cnt) <= RSP_CREDITS
  ) else $error("response credit count above its initial grant");

  // first reset edge still shows the power-up value
  a_no_credit_in_reset: assert property (
    @(posedge clk) reset && $past(reset) |-> !req_credit
  ) else $error("request credit returned during reset");

endmodule

bind spram_top spram_sva #(
  .RSP_CREDITS (RSP_CREDITS)
) u_sva (
  .clk        (clk),
  .reset      (reset),
  .req_credit (req_credit),
  .rsp_valid  (rsp_valid),
  .rsp_credit (rsp_credit),
  .credit_cnt (u_result.credit_cnt)
);

// ==== tests/tb_spram.sv ====
// Trace driven testbench for the tiled SRAM subsystem.
// Reads tests/spram_trace.txt, sends each command under request credits,
// returns response credits after random gaps and checks every read response.
// Run from the project root with the files.f compile list.

module tb_spram;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int REQ_DEPTH   = 4;
  localparam int RSP_CREDITS = 2;
  localparam int MAX_TESTS   = 64;

  logic                clk;
  logic                reset;
  logic                req_valid;
  spram_pkg::mem_req_t req;
  logic                req_credit;
  logic                rsp_valid;
  spram_pkg::mem_rsp_t rsp;
  logic                rsp_credit;

  logic [127:0]     t_name [MAX_TESTS];  // test name as ascii
  logic [7:0]       t_op   [MAX_TESTS];  // W R H C L
  spram_pkg::addr_t t_addr [MAX_TESTS];
  spram_pkg::mask_t t_mask [MAX_TESTS];
  spram_pkg::data_t t_data [MAX_TESTS];
  spram_pkg::tag_t  t_tag  [MAX_TESTS];
  spram_pkg::data_t t_exp  [MAX_TESTS];  // read data or response count for C

  int   n_tests = 0;
  logic trace_loaded = 1'b0;
  int   exp_q [$];          // trace index of each read in flight
  int   credits_spent = 0;  // request credits used by the driver
  int   credits_back = 0;   // req_credit pulses seen
  int   rsp_seen = 0;       // responses received
  int   rsp_returned = 0;   // rsp_credit pulses seen
  int   held_base = 0;      // rsp_seen when credits were frozen
  int   tests_done = 0;
  int   tests_failed = 0;
  int   errors = 0;
  logic hold = 1'b0;        // consumer keeps its credits
  logic [15:0] lfsr_state = 16'd24;

  spram_top #(
    .REQ_DEPTH   (REQ_DEPTH),
    .RSP_CREDITS (RSP_CREDITS),
    .TILE_W      (16),
    .TILE_ADDR_W (8)
  ) DUT (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int nbits, output int value);
    value = 0;
    for (int k = 0; k < nbits; k++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  function automatic int credits_avail();
    return REQ_DEPTH - credits_spent + credits_back;
  endfunction

  task automatic finish_test(input int i, input logic ok);
    tests_done++;
    if (ok) begin
      $display("test %0s passed", t_name[i]);
    end else begin
      tests_failed++;
      $display("test %0s failed", t_name[i]);
    end
  endtask

  task automatic load_trace();
    int fd;
    int n;
    string line;
    logic [127:0] nm;
    logic [7:0] op;
    logic [31:0] a, m, d, t, e;
    fd = $fopen("tests/spram_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file tests/spram_trace.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line[0] == "#") continue;  // blank or column notes
      n = $sscanf(line, "%s %s %h %h %h %h %h", nm, op, a, m, d, t, e);
      if (n != 7) begin
        $display("trace line could not be parsed: %s", line);
        errors++;
        continue;
      end
      t_name[n_tests] = nm;
      t_op[n_tests]   = op;
      t_addr[n_tests] = spram_pkg::addr_t'(a);
      t_mask[n_tests] = m;
      t_data[n_tests] = d;
      t_tag[n_tests]  = spram_pkg::tag_t'(t);
      t_exp[n_tests]  = e;
      n_tests++;
    end
    $fclose(fd);
  endtask

  // one single-cycle command per credit
  task automatic drive_request(input int i);
    while (credits_avail() == 0) @(negedge clk);
    req_valid = 1'b1;
    req = '{write: (t_op[i] == "W"), addr: t_addr[i], mask: t_mask[i],
            data: t_data[i], tag: t_tag[i]};
    credits_spent++;
    if (t_op[i] == "R") exp_q.push_back(i);
    @(negedge clk);
    req_valid = 1'b0;
    if (t_op[i] == "W") finish_test(i, 1'b1);  // write has no response
  endtask

  task automatic wait_for_drain();
    while (exp_q.size() != 0 || rsp_seen != rsp_returned) @(negedge clk);
    repeat (4) @(negedge clk);  // last credit pulse and pops settle
  endtask

  task automatic check_response();
    int   idx;
    logic ok;
    rsp_seen++;
    assert (exp_q.size() != 0) else begin
      $display("a response arrived while no read was outstanding");
      errors++;
    end
    if (exp_q.size() == 0) begin
      return;
    end
    idx = exp_q.pop_front();  // in order
    ok  = 1'b1;
    assert (rsp.tag == t_tag[idx]) else begin
      $display("MISMATCH %0s tag expected %h actual %h", t_name[idx], t_tag[idx], rsp.tag);
      ok = 1'b0;
      errors++;
    end
    assert (rsp.data == t_exp[idx]) else begin
      $display("MISMATCH %0s data expected %h actual %h", t_name[idx], t_exp[idx], rsp.data);
      ok = 1'b0;
      errors++;
    end
    finish_test(idx, ok);
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // all counters below change on the rising edge only
  always @(posedge clk) begin
    if (!reset) begin
      if (req_credit) begin
        credits_back++;
        assert (credits_avail() <= REQ_DEPTH) else begin
          $display("request credits held by the requester exceed the queue depth");
          errors++;
        end
      end
      if (rsp_credit) rsp_returned++;
      if (rsp_valid) check_response();
    end
  end

  initial begin : credit_return
    int gap;
    gap = 0;
    rsp_credit = 1'b0;
    forever begin
      @(negedge clk);
      rsp_credit = 1'b0;
      if (gap > 0) begin
        gap--;  // idle before next return
      end else if (!hold && rsp_seen > rsp_returned) begin
        rsp_credit = 1'b1;
        draw_bits(2, gap);  // 0 to 3 idle cycles
      end
    end
  end

  initial begin : watchdog
    wait (trace_loaded);
    repeat ((n_tests + 1) * 40) @(posedge clk);
    $display("timeout, the trace did not finish within %0d cycles", (n_tests + 1) * 40);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : stimulus
    int   got;
    logic ok;
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    load_trace();
    trace_loaded = 1'b1;
    if (n_tests == 0) begin
      $display("the trace holds no tests");
      errors++;
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);
    for (int i = 0; i < n_tests; i++) begin
      case (t_op[i])
        "W", "R": drive_request(i);
        "H": begin
          wait_for_drain();  // consumer starts with all credits
          hold <= 1'b1;
          held_base = rsp_seen;
          finish_test(i, 1'b1);
        end
        "C": begin
          repeat (20) @(negedge clk);
          ok  = 1'b1;
          got = rsp_seen - held_base;
          assert (got == int'(t_exp[i])) else begin
            $display("MISMATCH %0s expected %0d actual %0d", t_name[i], t_exp[i], got);
            ok = 1'b0;
            errors++;
          end
          finish_test(i, ok);
        end
        "L": begin
          hold <= 1'b0;
          finish_test(i, 1'b1);
        end
        default: begin
          $display("unknown operation in trace test %0s", t_name[i]);
          errors++;
        end
      endcase
    end
    wait_for_drain();
    assert (credits_avail() == REQ_DEPTH) else begin
      $display("MISMATCH request_credits expected %0d actual %0d", REQ_DEPTH, credits_avail());
      errors++;
    end
    $display("summary: %0d tests run, %0d tests failed, %0d failed checks",
             tests_done, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/spram_trace.txt ====
# columns: name op addr mask data tag expect, all numbers in hex
# op: W write, R read, H hold rsp credits, C count held responses, L release
wr_full_005     W 005 ffffffff 12345678 0 00000000
rd_full_005     R 005 00000000 00000000 1 12345678
wr_full_3ff     W 3ff ffffffff cafef00d 0 00000000
rd_full_3ff     R 3ff 00000000 00000000 2 cafef00d
wr_base_010     W 010 ffffffff aaaa5555 0 00000000
wr_half_010     W 010 00ff00ff 12345678 0 00000000
rd_half_010     R 010 00000000 00000000 3 aa345578
wr_top_010      W 010 ffff0000 deadbeef 0 00000000
rd_top_010      R 010 00000000 00000000 4 dead5578
wr_nib_010      W 010 0000000f 0000000c 0 00000000
rd_nib_010      R 010 00000000 00000000 5 dead557c
wr_bank0_020    W 020 ffffffff 11112222 0 00000000
wr_bank1_120    W 120 ffffffff 33334444 0 00000000
wr_bank2_220    W 220 ffffffff 55556666 0 00000000
wr_bank3_320    W 320 ffffffff 77778888 0 00000000
rd_bank0_020    R 020 00000000 00000000 6 11112222
rd_bank1_120    R 120 00000000 00000000 7 33334444
rd_bank2_220    R 220 00000000 00000000 8 55556666
rd_bank3_320    R 320 00000000 00000000 9 77778888
wr_lowcol_120   W 120 0000ffff 0000abcd 0 00000000
wr_hicol_220    W 220 ffff0000 9876ffff 0 00000000
rd_lowcol_120   R 120 00000000 00000000 a 3333abcd
rd_hicol_220    R 220 00000000 00000000 b 98766666
rd_bank0_again  R 020 00000000 00000000 c 11112222
rd_bank3_again  R 320 00000000 00000000 d 77778888
hold_credits    H 000 00000000 00000000 0 00000000
rd_hold_005     R 005 00000000 00000000 e 12345678
rd_hold_3ff     R 3ff 00000000 00000000 f cafef00d
rd_hold_010     R 010 00000000 00000000 0 dead557c
rd_hold_120     R 120 00000000 00000000 1 3333abcd
check_held      C 000 00000000 00000000 0 00000002
release_credits L 000 00000000 00000000 0 00000000
rd_after_220    R 220 00000000 00000000 2 98766666
wr_clr_0ff      W 0ff ffffffff 00000000 0 00000000
wr_pat_0ff      W 0ff f0f0f0f0 ffffffff 0 00000000
rd_pat_0ff      R 0ff 00000000 00000000 3 f0f0f0f0
wr_same_005     W 005 ffffffff 01020304 0 00000000
rd_same_005     R 005 00000000 00000000 4 01020304

// ==== files.f ====
common/spram_pkg.sv
mem_array/mem_tile.sv
mem_array/mem_array.sv
hw/spram_decode.sv
hw/spram_result.sv
hw/spram_top.sv
tests/spram_sva.sv
tests/tb_spram.sv

// ==== run.sh ====
#!/bin/sh
# Builds the SRAM subsystem testbench with Verilator and runs it.
# Exits non-zero when the build fails or the log does not show a pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module tb_spram -o sim_spram > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/sim_spram > sim.log 2>&1 ; cat sim.log

grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
